//--- compile.f
+incdir+design
design/conv1d_data_pkg.sv
design/conv1d_ctrl_pkg.sv
design/conv1d_wb_regs.sv
design/conv1d_operand_ram.sv
design/conv1d_mac_engine.sv
design/conv1d_top.sv
tests/conv1d_assert.sv
tests/conv1d_tb.sv

//--- run.sh
#!/bin/sh
# builds the testbench with verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module conv1d_tb \
  -f compile.f -o conv1d_sim \
  && ./obj_dir/conv1d_sim | tee /dev/stderr | grep -qx "Testbench passed" \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }

//--- tests/conv1d_tb.sv
/* testbench for the convolution accelerator: clock and reset, LCG stimulus,
   wishbone access tasks, byte level reference model, checker and watchdog */
`timescale 1ns/1ps
`default_nettype none
`include "conv1d_consts.svh"

module conv1d_tb;

  localparam int WIDE_TRIALS    = 24;
  localparam int NARROW_TRIALS  = 12;
  localparam int RESTART_TRIALS = 4;
  // the reset checks count as one more trial for the time budget
  localparam int TOTAL_TRIALS   = WIDE_TRIALS + NARROW_TRIALS + RESTART_TRIALS + 1;
  localparam int TRIAL_CYCLES   = 200 + 40 * `CONV_MAX_CHANNELS;
  localparam int ACK_LIMIT      = 8;
  localparam int POLL_LIMIT     = 4 * `CONV_MAX_CHANNELS + 20;
  localparam int BUF_BYTES      = `CONV_KERNEL_LEN * `CONV_MAX_CHANNELS;

  logic        clk;
  logic        arst_n;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [11:0] wb_adr;
  logic [31:0] wb_dat_w;
  logic        wb_ack;
  logic [31:0] wb_dat_r;

  logic [31:0]      rng_state;
  int               errors;
  int               checks;
  // host side mirror of both operand buffers, one entry per int8 byte
  logic signed [7:0] in_mem  [BUF_BYTES];
  logic signed [7:0] flt_mem [BUF_BYTES];

  conv1d_top u_dut (
    .clk      (clk),
    .arst_n   (arst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_ack   (wb_ack),
    .wb_dat_r (wb_dat_r)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] next_random();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // dot product over the whole kernel, the input read as a ring of
  // kernel_len * depth bytes starting at byte start_x * depth
  function automatic int model_acc(int depth, int start_x, int in_offset);
    int ring;
    int idx;
    int acc;
    ring = `CONV_KERNEL_LEN * depth;
    acc  = 0;
    for (int k = 0; k < ring; k++) begin
      idx = (start_x * depth + k) % ring;
      acc = acc + int'(flt_mem[k]) * (int'(in_mem[idx]) + in_offset);
    end
    return acc;
  endfunction

  // lower bound first, then the upper bound
  function automatic int clamp_model(int raw, int act_min, int act_max);
    int v;
    v = (raw < act_min) ? act_min : raw;
    return (v > act_max) ? act_max : v;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("Mismatch %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  // one classic cycle, ack is expected on the first edge after stb
  task automatic bus_access(input logic we, input logic [11:0] adr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    int   waited;
    logic got_ack;
    @(posedge clk);
    #1;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdata;
    waited   = 0;
    got_ack  = 1'b0;
    while (!got_ack && waited < ACK_LIMIT) begin
      @(posedge clk);
      #1;
      waited++;
      got_ack = wb_ack;
    end
    if (!got_ack) begin
      $display("no ack within %0d cycles for address %h", ACK_LIMIT, adr);
      errors++;
    end else begin
      check_value("ack_cycles", 32'(waited), 32'd1);
    end
    rdata  = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic write_word(input logic [11:0] adr, input logic [31:0] data);
    logic [31:0] unused;
    bus_access(1'b1, adr, data, unused);
  endtask

  task automatic read_word(input logic [11:0] adr, output logic [31:0] data);
    bus_access(1'b0, adr, 32'd0, data);
  endtask

  // fills the part of both buffers that a run of this depth touches
  task automatic load_buffers(input int depth);
    logic [31:0] word;
    for (int w = 0; w < 2 * depth; w++) begin
      word = next_random();
      for (int b = 0; b < `CONV_LANES; b++) begin
        in_mem[4 * w + b] = word[8 * b +: 8];
      end
      write_word(`CONV_ADR_INPUT + 12'(4 * w), word);
      word = next_random();
      for (int b = 0; b < `CONV_LANES; b++) begin
        flt_mem[4 * w + b] = word[8 * b +: 8];
      end
      write_word(`CONV_ADR_FILTER + 12'(4 * w), word);
    end
  endtask

  task automatic wait_done();
    logic [31:0] rdata;
    int          polls;
    polls = 0;
    rdata = '0;
    while (rdata[0] !== 1'b1 && polls < POLL_LIMIT) begin
      read_word(`CONV_ADR_CTRL, rdata);
      polls++;
    end
    if (rdata[0] !== 1'b1) begin
      $display("done did not come back after %0d polls of the control register", polls);
      errors++;
    end
  endtask

  // a narrow window is placed around the unclamped value so that both
  // bounds get hit now and then
  task automatic run_trial(input int depth, input bit narrow, input bit restart);
    logic [31:0] r;
    logic [31:0] rdata;
    int          start_x;
    int          in_offset;
    int          out_offset;
    int          bias;
    int          raw;
    int          act_min;
    int          act_max;
    load_buffers(depth);
    r          = next_random();
    start_x    = int'(r[2:0]);
    in_offset  = int'(r[15:8]) - 128;
    out_offset = int'(r[23:16]) - 128;
    r          = next_random();
    bias       = int'(r[15:0]) - 32768;
    raw        = model_acc(depth, start_x, in_offset) + bias + out_offset;
    if (narrow) begin
      r       = next_random();
      act_min = raw + int'(r[8:0]) - 256;
      act_max = act_min + int'(r[24:16]);
    end else begin
      act_min = 32'h8000_0000;
      act_max = 32'h7fff_ffff;
    end
    write_word(`CONV_ADR_IN_OFFSET, in_offset);
    write_word(`CONV_ADR_DEPTH, depth);
    write_word(`CONV_ADR_START_X, start_x);
    write_word(`CONV_ADR_BIAS, bias);
    write_word(`CONV_ADR_ACT_MIN, act_min);
    write_word(`CONV_ADR_ACT_MAX, act_max);
    write_word(`CONV_ADR_OUT_OFFSET, out_offset);
    write_word(`CONV_ADR_CTRL, 32'd1);
    read_word(`CONV_ADR_CTRL, rdata);
    check_value("ctrl_done_busy", rdata, 32'd0);
    // the engine is busy here so this start must be dropped
    if (restart) begin
      write_word(`CONV_ADR_CTRL, 32'd1);
    end
    wait_done();
    read_word(`CONV_ADR_RESULT, rdata);
    check_value("result", rdata, clamp_model(raw, act_min, act_max));
    // a dropped start leaves no second run pending behind the first one
    if (restart) begin
      read_word(`CONV_ADR_CTRL, rdata);
      check_value("ctrl_done_after", rdata, 32'd1);
    end
  endtask

  initial begin
    #(TOTAL_TRIALS * TRIAL_CYCLES * 10);
    $display("watchdog expired after %0d cycles, the run did not finish",
             TOTAL_TRIALS * TRIAL_CYCLES);
    $display("Testbench failed");
    $finish;
  end

  initial begin
    logic [31:0] rdata;
    clk       = 1'b0;
    arst_n    = 1'b0;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_adr    = '0;
    wb_dat_w  = '0;
    rng_state = 32'd94;
    errors    = 0;
    checks    = 0;
    repeat (3) @(posedge clk);
    #1;
    arst_n = 1'b1;

    // idle state straight out of reset
    read_word(`CONV_ADR_CTRL, rdata);
    check_value("ctrl_done_reset", rdata, 32'd1);
    read_word(`CONV_ADR_RESULT, rdata);
    check_value("result_reset", rdata, 32'd0);

    for (int t = 0; t < WIDE_TRIALS; t++) begin
      run_trial((t % 2 == 0) ? 8 : 16, 1'b0, 1'b0);
    end
    for (int t = 0; t < NARROW_TRIALS; t++) begin
      run_trial((t % 2 == 0) ? 16 : 8, 1'b1, 1'b0);
    end
    for (int t = 0; t < RESTART_TRIALS; t++) begin
      run_trial((t % 2 == 0) ? 8 : 16, 1'b0, 1'b1);
    end

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/conv1d_assert.sv
/* concurrent checks on the wishbone handshake and the start/done
   control of the register file, bound into conv1d_wb_regs */
`timescale 1ns/1ps
`default_nettype none

module conv1d_assert (
  input logic clk,
  input logic arst_n,
  input logic wb_cyc,
  input logic wb_stb,
  input logic wb_ack,
  input logic start,
  input logic done
);

  // ack is only ever an answer to a request seen on the previous edge
  ack_follows_request: assert property (@(posedge clk) disable iff (!arst_n)
    wb_ack |-> $past(wb_cyc && wb_stb))
    else $error("ack raised without cyc and stb on the previous cycle");

  // every access gets exactly one cycle of ack
  ack_single_cycle: assert property (@(posedge clk) disable iff (!arst_n)
    wb_ack |=> !wb_ack)
    else $error("ack held high for two cycles");

  // the engine may only be started from idle
  start_when_idle: assert property (@(posedge clk) disable iff (!arst_n)
    start |-> done)
    else $error("start pulse while the engine was busy");

endmodule

bind conv1d_wb_regs conv1d_assert u_assert (
  .clk    (clk),
  .arst_n (arst_n),
  .wb_cyc (wb_cyc),
  .wb_stb (wb_stb),
  .wb_ack (wb_ack),
  .start  (start),
  .done   (done)
);

`default_nettype wire

//--- design/conv1d_top.sv
/* top level of the convolution accelerator: wishbone register file,
   banked operand memory and the MAC engine */
`timescale 1ns/1ps
`default_nettype none

module conv1d_top (
  input  logic        clk,
  input  logic        arst_n,
  input  logic        wb_cyc,
  input  logic        wb_stb,
  input  logic        wb_we,
  input  logic [11:0] wb_adr,
  input  logic [31:0] wb_dat_w,
  output logic        wb_ack,
  output logic [31:0] wb_dat_r
);
  import conv1d_data_pkg::*;
  import conv1d_ctrl_pkg::*;

  buf_wr_t       buf_wr;
  conv_params_t  params;
  logic          start;
  logic          done;
  acc_t          result;
  logic          rd_en;
  row_idx_t      rd_row_in;
  row_idx_t      rd_row_flt;
  operand_word_u in_even;
  operand_word_u in_odd;
  operand_word_u flt_even;
  operand_word_u flt_odd;

  // host side, feeds the buffers and the engine parameters
  conv1d_wb_regs u_regs (
    .clk      (clk),
    .arst_n   (arst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_ack   (wb_ack),
    .wb_dat_r (wb_dat_r),
    .buf_wr   (buf_wr),
    .params   (params),
    .start    (start),
    .done     (done),
    .result   (result)
  );

  conv1d_operand_ram u_ram (
    .clk        (clk),
    .buf_wr     (buf_wr),
    .rd_en      (rd_en),
    .rd_row_in  (rd_row_in),
    .rd_row_flt (rd_row_flt),
    .in_even    (in_even),
    .in_odd     (in_odd),
    .flt_even   (flt_even),
    .flt_odd    (flt_odd)
  );

  // consumer of the buffers, reports back through done and result
  conv1d_mac_engine u_engine (
    .clk        (clk),
    .arst_n     (arst_n),
    .start      (start),
    .params     (params),
    .in_even    (in_even),
    .in_odd     (in_odd),
    .flt_even   (flt_even),
    .flt_odd    (flt_odd),
    .rd_en      (rd_en),
    .rd_row_in  (rd_row_in),
    .rd_row_flt (rd_row_flt),
    .done       (done),
    .result     (result)
  );

endmodule

`default_nettype wire

//--- design/conv1d_mac_engine.sv
/* convolution engine: ring walk over the input pairs, eight-lane
   multiply-accumulate and the bias/offset/clamp requantization */
`timescale 1ns/1ps
`default_nettype none
`include "conv1d_consts.svh"

module conv1d_mac_engine (
  input  logic                           clk,
  input  logic                           arst_n,
  input  logic                           start,
  input  conv1d_ctrl_pkg::conv_params_t  params,
  input  conv1d_data_pkg::operand_word_u in_even,
  input  conv1d_data_pkg::operand_word_u in_odd,
  input  conv1d_data_pkg::operand_word_u flt_even,
  input  conv1d_data_pkg::operand_word_u flt_odd,
  output logic                           rd_en,
  output conv1d_data_pkg::row_idx_t      rd_row_in,
  output conv1d_data_pkg::row_idx_t      rd_row_flt,
  output logic                           done,
  output conv1d_ctrl_pkg::acc_t          result
);
  import conv1d_data_pkg::*;
  import conv1d_ctrl_pkg::*;

  localparam int ROW_W      = $bits(row_idx_t);
  localparam int STEP_W     = ROW_W + 1;
  localparam int TAP_BITS   = $clog2(`CONV_KERNEL_LEN);
  localparam int PAIR_SHIFT = $clog2(2 * `CONV_LANES);

  eng_state_e        state;
  acc_t              acc;
  acc_t              lane_sum;
  acc_t              biased;
  acc_t              floored;
  row_idx_t          row_in;
  row_idx_t          row_flt;
  row_idx_t          ring_last;
  row_idx_t          start_pair;
  logic [STEP_W-1:0] steps_left;
  operand_word_u     in_w [2];
  operand_word_u     flt_w [2];

  // the ring holds kernel_len * depth bytes, i.e. depth pairs, so the byte
  // start start_x * depth modulo that size is (start_x mod 8) * depth / 8
  // pairs and never needs a divider
  assign start_pair = row_idx_t'(params.start_x[TAP_BITS-1:0] * (params.depth >> PAIR_SHIFT));

  assign in_w[0]  = in_even;
  assign in_w[1]  = in_odd;
  assign flt_w[0] = flt_even;
  assign flt_w[1] = flt_odd;

  // sum of the eight products of one pair, all arithmetic in 32 bits
  always_comb begin
    lane_sum = '0;
    for (int w = 0; w < 2; w++) begin
      for (int l = 0; l < `CONV_LANES; l++) begin
        lane_sum = lane_sum + acc_t'(flt_w[w].lane[l]) *
                   (acc_t'(in_w[w].lane[l]) + params.in_offset);
      end
    end
  end

  // max against act_min first, min against act_max is applied on store
  assign biased  = acc + params.bias + params.out_offset;
  assign floored = (biased < params.act_min) ? params.act_min : biased;

  assign rd_en      = (state == ENG_READ);
  assign rd_row_in  = row_in;
  assign rd_row_flt = row_flt;
  assign done       = (state == ENG_IDLE);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state      <= ENG_IDLE;
      acc        <= '0;
      row_in     <= '0;
      row_flt    <= '0;
      ring_last  <= '0;
      steps_left <= '0;
      result     <= '0;
    end else begin
      case (state)
        ENG_IDLE: begin
          if (start) begin
            acc        <= '0;
            row_flt    <= '0;
            row_in     <= start_pair;
            ring_last  <= row_idx_t'(params.depth - 1);
            steps_left <= STEP_W'(params.depth);
            // zero depth skips the walk and just requantizes the bias
            state      <= (params.depth == 0) ? ENG_QUANT : ENG_READ;
          end
        end
        // the pair read issued here is valid in the next state
        ENG_READ: state <= ENG_ACC;
        ENG_ACC: begin
          acc        <= acc + lane_sum;
          row_flt    <= row_flt + 1'b1;
          row_in     <= (row_in == ring_last) ? '0 : row_in + 1'b1;
          steps_left <= steps_left - 1'b1;
          state      <= (steps_left == 1) ? ENG_QUANT : ENG_READ;
        end
        ENG_QUANT: begin
          result <= (floored > params.act_max) ? params.act_max : floored;
          state  <= ENG_IDLE;
        end
        default: state <= ENG_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- design/conv1d_operand_ram.sv
/* input and filter operand memories split into even and odd banks,
   written word by word from the host and read as registered pairs */
`timescale 1ns/1ps
`default_nettype none
`include "conv1d_consts.svh"

module conv1d_operand_ram (
  input  logic                           clk,
  input  conv1d_data_pkg::buf_wr_t       buf_wr,
  input  logic                           rd_en,
  input  conv1d_data_pkg::row_idx_t      rd_row_in,
  input  conv1d_data_pkg::row_idx_t      rd_row_flt,
  output conv1d_data_pkg::operand_word_u in_even,
  output conv1d_data_pkg::operand_word_u in_odd,
  output conv1d_data_pkg::operand_word_u flt_even,
  output conv1d_data_pkg::operand_word_u flt_odd
);
  import conv1d_data_pkg::*;

  // bank number is {filter, odd}
  localparam int NUM_BANKS = 4;

  operand_word_u rd_q [NUM_BANKS];

  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    localparam bit IS_FLT = (b >= 2);
    localparam bit IS_ODD = ((b % 2) == 1);

    operand_word_u mem [`CONV_BANK_WORDS];
    row_idx_t      rd_row;
    logic          wr_hit;

    // both banks of one buffer share a row, so a pair comes out together
    assign rd_row = IS_FLT ? rd_row_flt : rd_row_in;
    assign wr_hit = buf_wr.en && (buf_wr.flt == IS_FLT) && (buf_wr.odd == IS_ODD);

    // single write port and one registered read port per bank
    always_ff @(posedge clk) begin
      if (wr_hit) begin
        mem[buf_wr.row] <= buf_wr.data;
      end
      if (rd_en) begin
        rd_q[b] <= mem[rd_row];
      end
    end
  end

  assign in_even  = rd_q[0];
  assign in_odd   = rd_q[1];
  assign flt_even = rd_q[2];
  assign flt_odd  = rd_q[3];

endmodule

`default_nettype wire

//--- design/conv1d_wb_regs.sv
/* wishbone classic slave with the parameter registers, operand buffer
   write generation and the start/done handshake towards the engine */
`timescale 1ns/1ps
`default_nettype none
`include "conv1d_consts.svh"

module conv1d_wb_regs (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic                          wb_cyc,
  input  logic                          wb_stb,
  input  logic                          wb_we,
  input  logic [11:0]                   wb_adr,
  input  logic [31:0]                   wb_dat_w,
  output logic                          wb_ack,
  output logic [31:0]                   wb_dat_r,
  output conv1d_data_pkg::buf_wr_t      buf_wr,
  output conv1d_ctrl_pkg::conv_params_t params,
  output logic                          start,
  input  logic                          done,
  input  conv1d_ctrl_pkg::acc_t         result
);
  import conv1d_data_pkg::*;
  import conv1d_ctrl_pkg::*;

  // byte span of one operand buffer, both banks together
  localparam int BUF_ADR_BITS = $clog2(2 * `CONV_BANK_WORDS * `CONV_LANES);
  localparam logic [11:0] ADR_INPUT  = `CONV_ADR_INPUT;
  localparam logic [11:0] ADR_FILTER = `CONV_ADR_FILTER;

  logic [11:0] word_adr;
  logic        access;
  logic        wr_access;
  logic        hit_input;
  logic        hit_filter;

  // byte lane bits carry no meaning, every register is a full word
  assign word_adr = {wb_adr[11:2], 2'b00};

  // an access is taken on the edge that raises ack, so the cycle with ack
  // high never counts a second time
  assign access    = wb_cyc && wb_stb && !wb_ack;
  assign wr_access = access && wb_we;

  assign hit_input  = word_adr[11:BUF_ADR_BITS] == ADR_INPUT[11:BUF_ADR_BITS];
  assign hit_filter = word_adr[11:BUF_ADR_BITS] == ADR_FILTER[11:BUF_ADR_BITS];

  // word index bit 0 picks the bank, the rest is the row inside it
  always_comb begin
    buf_wr.en       = wr_access && (hit_input || hit_filter);
    buf_wr.flt      = hit_filter;
    buf_wr.odd      = wb_adr[2];
    buf_wr.row      = wb_adr[BUF_ADR_BITS-1:3];
    buf_wr.data.raw = wb_dat_w;
  end

  // parameter registers are written on the ack edge
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      params <= '0;
    end else if (wr_access) begin
      case (word_adr)
        `CONV_ADR_IN_OFFSET:  params.in_offset  <= wb_dat_w;
        `CONV_ADR_DEPTH:      params.depth      <= wb_dat_w;
        `CONV_ADR_START_X:    params.start_x    <= wb_dat_w;
        `CONV_ADR_BIAS:       params.bias       <= wb_dat_w;
        `CONV_ADR_ACT_MIN:    params.act_min    <= wb_dat_w;
        `CONV_ADR_ACT_MAX:    params.act_max    <= wb_dat_w;
        `CONV_ADR_OUT_OFFSET: params.out_offset <= wb_dat_w;
        default: ;
      endcase
    end
  end

  // ack, read data and start all come out of registers
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wb_ack   <= 1'b0;
      wb_dat_r <= '0;
      start    <= 1'b0;
    end else begin
      wb_ack <= access;

      // a ctrl write during a run is acknowledged and dropped here
      start <= wr_access && (word_adr == `CONV_ADR_CTRL) && done;

      if (access && !wb_we) begin
        case (word_adr)
          `CONV_ADR_CTRL:   wb_dat_r <= {{31{1'b0}}, done};
          `CONV_ADR_RESULT: wb_dat_r <= result;
          default:          wb_dat_r <= '0;
        endcase
      end else begin
        wb_dat_r <= '0;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/conv1d_ctrl_pkg.sv
/* control side types: accumulator word, the host parameter bundle
   and the engine state encoding */
`default_nettype none

package conv1d_ctrl_pkg;

  // accumulator and result word, wraps modulo 2^32
  typedef logic signed [31:0] acc_t;

  // fields follow the register order of the address map
  typedef struct packed {
    logic signed [31:0] in_offset;
    logic signed [31:0] depth;
    logic signed [31:0] start_x;
    logic signed [31:0] bias;
    logic signed [31:0] act_min;
    logic signed [31:0] act_max;
    logic signed [31:0] out_offset;
  } conv_params_t;

  // idle doubles as the done status seen by the host
  typedef enum logic [1:0] {
    ENG_IDLE,
    ENG_READ,
    ENG_ACC,
    ENG_QUANT
  } eng_state_e;

endpackage

`default_nettype wire

//--- design/conv1d_data_pkg.sv
/* operand data types: signed int8 lane, the raw/lane view of a buffer
   word, the bank row index and the buffer write request */
`default_nettype none
`include "conv1d_consts.svh"

package conv1d_data_pkg;

  typedef logic signed [7:0] int8_t;

  // the host sees a plain 32-bit word, the engine sees four signed lanes
  // with lane 0 taken from the low byte
  typedef union packed {
    logic [31:0]                  raw;
    int8_t [`CONV_LANES-1:0]      lane;
  } operand_word_u;

  // row within one even or odd bank
  typedef logic [$clog2(`CONV_BANK_WORDS)-1:0] row_idx_t;

  // one write into the banked operand memory
  typedef struct packed {
    logic          en;
    logic          flt;
    logic          odd;
    row_idx_t      row;
    operand_word_u data;
  } buf_wr_t;

endpackage

`default_nettype wire

//--- design/conv1d_consts.svh
/* compile-time limits of the int8 convolution engine, operand packing,
   bank depth and the wishbone byte address map of the register file */
`ifndef CONV1D_CONSTS_SVH
`define CONV1D_CONSTS_SVH

// number of kernel taps, also the ring length in units of one input depth
`define CONV_KERNEL_LEN 8

// largest supported input depth, must stay a multiple of eight
`define CONV_MAX_CHANNELS 16

// int8 lanes packed into one 32-bit operand word
`define CONV_LANES 4

// one step consumes an even/odd word pair, so each bank holds half the words
`define CONV_BANK_WORDS ((`CONV_KERNEL_LEN * `CONV_MAX_CHANNELS) / (2 * `CONV_LANES))

// operand buffer regions
`define CONV_ADR_INPUT  12'h000
`define CONV_ADR_FILTER 12'h100

// parameter registers, one 32-bit word each
`define CONV_ADR_IN_OFFSET  12'h200
`define CONV_ADR_DEPTH      12'h204
`define CONV_ADR_START_X    12'h208
`define CONV_ADR_BIAS       12'h20C
`define CONV_ADR_ACT_MIN    12'h210
`define CONV_ADR_ACT_MAX    12'h214
`define CONV_ADR_OUT_OFFSET 12'h218

// writing ctrl starts a run, reading it returns done in bit 0
`define CONV_ADR_CTRL   12'h21C
`define CONV_ADR_RESULT 12'h220

`endif
